// File: beam_power.f
hdl/beam_power_pkg.sv
hdl/rbg_boundary_gen.sv
hdl/beam_power_calc.sv
hdl/power_table.sv
hdl/wb_power_regs.sv
hdl/beam_power_top.sv
tests/beam_power_assert.sv
tests/beam_power_tb.sv

// File: Makefile
TOP := beam_power_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f beam_power.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing --assert -f beam_power.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tests/beam_power_tb.sv
// beam power testbench: clock, reset, stream driver, wishbone tasks, reference model, directed tests
`timescale 1ns/10ps
`default_nettype none

module beam_power_tb;
    import beam_power_pkg::*;

    localparam int N_TESTS = 6;
    localparam logic [15:0] EDGE_VALS [8] = '{16'h8000, 16'h7fff, 16'hffff, 16'h0001,
                                               16'hfff0, 16'h000f, 16'h8001, 16'h0010};

    logic              clk = 1'b0;
    logic              rst;
    logic [3:0][15:0]  data_re;
    logic [3:0][15:0]  data_im;
    logic              data_vld;
    logic              data_sop;
    logic              data_eop;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [WB_AW-1:0]  wb_adr;
    logic [WB_DW-1:0]  wb_dat_w;
    logic [WB_DW-1:0]  wb_dat_r;
    logic              wb_ack;
    logic              irq;

    // stimulus and reference state
    logic [63:0] stim_re[$];
    logic [63:0] stim_im[$];
    bit          stim_eop[$];
    int          eop_cycles[$];
    int          irq_cycles[$];
    logic [31:0] exp_tbl [256][4];
    bit          exp_valid [256];
    int          exp_symbs = 0;
    int          exp_rbgs = 0;
    int          cyc_cnt = 0;
    int          n_mismatch = 0;
    int          n_error = 0;
    int          n_assert = 0;

    beam_power_top #(.BEAM(4), .IW(16), .OW(32)) dut0 (
        .i_clk(clk), .i_rst(rst),
        .i_data_re(data_re), .i_data_im(data_im), .i_data_vld(data_vld),
        .i_data_sop(data_sop), .i_data_eop(data_eop),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_adr(wb_adr), .i_wb_dat(wb_dat_w),
        .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack), .o_irq_symb_done(irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

    always @(negedge clk) begin
        if (irq === 1'b1) begin
            irq_cycles.push_back(cyc_cnt);
        end
    end

    // --------------------
    // helpers
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        n_mismatch++;
        $display("MISMATCH %s: expected %08h actual %08h", name, exp, act);
    endtask

    function automatic logic [WB_AW-1:0] tbl_addr(input int r, input int b);
        wb_addr_u a;
        a.tbl.sel  = 1'b1;
        a.tbl.rbg  = RBG_AW'(r);
        a.tbl.beam = BEAM_IW'(b);
        return a;
    endfunction

    function automatic logic [WB_AW-1:0] reg_addr(input logic [3:0] idx);
        wb_addr_u a;
        a = '0;
        a.regs.idx = idx;
        return a;
    endfunction

    task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack !== 1'b1 && waited < 10);
        if (wb_ack !== 1'b1) begin
            n_error++;
            $display("no Wishbone ack within 10 cycles at address %03h", adr);
        end
        rdat = wb_dat_r;
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] wdat);
        logic [WB_DW-1:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic clear_stim();
        stim_re.delete();
        stim_im.delete();
        stim_eop.delete();
        eop_cycles.delete();
        irq_cycles.delete();
    endtask

    task automatic add_random_symbol(input int n);
        for (int i = 0; i < n; i++) begin
            stim_re.push_back({$urandom, $urandom});
            stim_im.push_back({$urandom, $urandom});
            stim_eop.push_back(i == n - 1);
        end
    endtask

    // holes are idle cycles drawn with the given percentage
    task automatic send_stream(input int hole_pct);
        int  i;
        logic sop;
        i   = 0;
        sop = 1'b1;
        while (i < stim_re.size()) begin
            @(posedge clk);
            #2;
            if (hole_pct > 0 && int'($urandom % 100) < hole_pct) begin
                data_vld = 1'b0;
                data_sop = 1'b0;
                data_eop = 1'b0;
            end else begin
                data_re  = stim_re[i];
                data_im  = stim_im[i];
                data_vld = 1'b1;
                data_sop = sop;
                data_eop = stim_eop[i];
                if (stim_eop[i]) begin
                    eop_cycles.push_back(cyc_cnt);
                end
                sop = stim_eop[i];
                i++;
            end
        end
        @(posedge clk);
        #2;
        data_vld = 1'b0;
        data_sop = 1'b0;
        data_eop = 1'b0;
    endtask

    // --------------------
    // reference model
    function automatic int beam_mag(input logic [15:0] re, input logic [15:0] im);
        int sr;
        int si;
        sr = int'($signed(re)) >>> PWR_SHIFT;
        si = int'($signed(im)) >>> PWR_SHIFT;
        return (sr < 0 ? -sr : sr) + (si < 0 ? -si : si);
    endfunction

    task automatic model_stream(input int size);
        int          len;
        int          cnt;
        int          rbg;
        logic [31:0] acc [4];
        bit          sop;
        len = 48 << ((size == 3) ? 2 : size);
        cnt = 0;
        rbg = 0;
        sop = 1'b1;
        for (int i = 0; i < stim_re.size(); i++) begin
            if (sop) begin
                rbg = 0;
                cnt = 0;
            end
            for (int b = 0; b < 4; b++) begin
                if (cnt == 0) begin
                    acc[b] = '0;
                end
                acc[b] += 32'(beam_mag(stim_re[i][b*16 +: 16], stim_im[i][b*16 +: 16]));
            end
            cnt++;
            if (cnt == len || stim_eop[i]) begin
                for (int b = 0; b < 4; b++) begin
                    exp_tbl[rbg][b] = acc[b];
                end
                exp_valid[rbg] = 1'b1;
                rbg++;
                cnt = 0;
                if (stim_eop[i]) begin
                    exp_symbs++;
                    exp_rbgs = rbg;
                end
            end
            sop = stim_eop[i];
        end
    endtask

    task automatic wait_irqs(input int n);
        int waited;
        waited = 0;
        while (irq_cycles.size() < n && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (irq_cycles.size() < n) begin
            n_error++;
            $display("symbol done interrupt missing, saw %0d of %0d", irq_cycles.size(), n);
        end
    endtask

    task automatic check_table();
        logic [31:0] rd;
        for (int r = 0; r < 256; r++) begin
            for (int b = 0; b < 4; b++) begin
                if (exp_valid[r]) begin
                    wb_read(tbl_addr(r, b), rd);
                    if (rd !== exp_tbl[r][b]) begin
                        report_mismatch($sformatf("o_wb_dat rbg %0d beam %0d", r, b),
                                        exp_tbl[r][b], rd);
                    end
                end
            end
        end
    endtask

    task automatic check_status();
        logic [31:0] rd;
        logic [31:0] exp;
        exp = {8'h00, RBG_AW'(exp_rbgs), 16'(exp_symbs)};
        wb_read(reg_addr(REG_STAT), rd);
        if (rd !== exp) report_mismatch("o_wb_dat status", exp, rd);
    endtask

    // --------------------
    // directed tests
    task automatic test_reg_access();
        logic [31:0] rd;
        wb_read(reg_addr(REG_CTRL), rd);
        if (rd !== 32'h4) report_mismatch("o_wb_dat ctrl after reset", 32'h4, rd);
        check_status();
        wb_write(reg_addr(REG_CTRL), 32'h3);
        wb_read(reg_addr(REG_CTRL), rd);
        if (rd !== 32'h3) report_mismatch("o_wb_dat ctrl", 32'h3, rd);
    endtask

    task automatic test_small_rbg();
        clear_stim();
        wb_write(reg_addr(REG_CTRL), 32'h1);
        add_random_symbol(96);
        send_stream(0);
        model_stream(0);
        wait_irqs(1);
        check_table();
        check_status();
    endtask

    task automatic test_holes_remainder();
        clear_stim();
        wb_write(reg_addr(REG_CTRL), 32'h5);
        add_random_symbol(200);
        send_stream(25);
        model_stream(2);
        wait_irqs(1);
        check_table();
        check_status();
    endtask

    // full scale negative and mixed sign samples
    task automatic test_extremes();
        logic [63:0] w_re;
        logic [63:0] w_im;
        clear_stim();
        wb_write(reg_addr(REG_CTRL), 32'h1);
        for (int i = 0; i < 60; i++) begin
            for (int b = 0; b < 4; b++) begin
                w_re[b*16 +: 16] = EDGE_VALS[(i + b) % 8];
                w_im[b*16 +: 16] = EDGE_VALS[(i + 3 * b + 1) % 8];
            end
            stim_re.push_back(w_re);
            stim_im.push_back(w_im);
            stim_eop.push_back(i == 59);
        end
        send_stream(0);
        model_stream(0);
        wait_irqs(1);
        check_table();
        check_status();
    endtask

    task automatic test_disabled();
        clear_stim();
        wb_write(reg_addr(REG_CTRL), 32'h0);
        add_random_symbol(96);
        send_stream(10);
        // longer than the stream to write latency
        repeat (12) @(posedge clk);
        if (irq_cycles.size() != 0) begin
            n_error++;
            $display("symbol done interrupt pulsed while disabled");
        end
        check_table();
        check_status();
    endtask

    task automatic test_back_to_back();
        clear_stim();
        wb_write(reg_addr(REG_CTRL), 32'h3);
        add_random_symbol(200);
        add_random_symbol(200);
        send_stream(0);
        model_stream(1);
        wait_irqs(2);
        if (irq_cycles.size() != 2 || eop_cycles.size() != 2) begin
            n_error++;
            $display("expected two symbol done pulses, saw %0d", irq_cycles.size());
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (irq_cycles[k] != eop_cycles[k] + 5) begin
                    report_mismatch("o_irq_symb_done cycle", 32'(eop_cycles[k] + 5),
                                    32'(irq_cycles[k]));
                end
            end
        end
        check_table();
        check_status();
    endtask

    // --------------------
    // run
    initial begin
        void'($urandom(32'h19d5b926));
        rst      = 1'b1;
        data_re  = '0;
        data_im  = '0;
        data_vld = 1'b0;
        data_sop = 1'b0;
        data_eop = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reg_access();
        test_small_rbg();
        test_holes_remainder();
        test_extremes();
        test_disabled();
        test_back_to_back();
        n_assert = dut0.u_regs.u_wb_assert.n_fail;
        $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 n_mismatch, n_error, n_assert);
        if (n_mismatch + n_error + n_assert == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(N_TESTS * 40_000);
        $display("watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/beam_power_assert.sv
// wishbone handshake assertions with a failure count, bound to the register block
`timescale 1ns/10ps
`default_nettype none

module beam_power_assert (
    input wire logic i_clk,
    input wire logic i_rst,
    input wire logic i_wb_cyc,
    input wire logic i_wb_stb,
    input wire logic i_wb_ack
);

    int n_fail = 0;

    // --------------------
    // wishbone handshake
    a_ack_with_req: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else begin
            n_fail++;
            $error("ack without an active cyc and stb");
        end

    a_ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_ack |=> !i_wb_ack)
        else begin
            n_fail++;
            $error("ack held for two cycles");
        end

    a_no_ack_in_reset: assert property (@(posedge i_clk)
        i_rst |=> !i_wb_ack)
        else begin
            n_fail++;
            $error("ack after a reset cycle");
        end

endmodule

bind wb_power_regs beam_power_assert u_wb_assert (
    .i_clk(i_clk), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
    .i_wb_ack(o_wb_ack)
);

`default_nettype wire

// File: hdl/beam_power_top.sv
// beam power top level: boundary generator, power calculator, power table and wishbone registers
`timescale 1ns/10ps
`default_nettype none

module beam_power_top #(
    parameter int BEAM = 4,
    parameter int IW   = 16,
    parameter int OW   = 32
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic [BEAM-1:0][IW-1:0]          i_data_re,
    input  logic [BEAM-1:0][IW-1:0]          i_data_im,
    input  logic                             i_data_vld,
    input  logic                             i_data_sop,
    input  logic                             i_data_eop,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [beam_power_pkg::WB_AW-1:0] i_wb_adr,
    input  logic [beam_power_pkg::WB_DW-1:0] i_wb_dat,
    output logic [beam_power_pkg::WB_DW-1:0] o_wb_dat,
    output logic                             o_wb_ack,
    output logic                             o_irq_symb_done
);
    import beam_power_pkg::*;

    logic                      en;
    logic [1:0]                rbg_size;
    // boundary generator to calculator
    logic [BEAM-1:0][IW-1:0]   bnd_re;
    logic [BEAM-1:0][IW-1:0]   bnd_im;
    logic                      bnd_vld;
    logic                      bnd_first;
    logic                      bnd_last;
    logic [RBG_AW-1:0]         bnd_num;
    logic                      bnd_end;
    // calculator to table and registers
    logic [BEAM-1:0][OW-1:0]   sum_data;
    logic [RBG_AW-1:0]         sum_addr;
    logic                      sum_wen;
    logic                      symb_done;
    logic [RBG_AW+BEAM_IW-1:0] tbl_raddr;
    logic [OW-1:0]             tbl_rdata;

    rbg_boundary_gen #(.BEAM(BEAM), .IW(IW)) u_bnd (
        .i_clk(i_clk), .i_rst(i_rst), .i_en(en), .i_rbg_size(rbg_size),
        .i_data_re(i_data_re), .i_data_im(i_data_im), .i_data_vld(i_data_vld),
        .i_data_sop(i_data_sop), .i_data_eop(i_data_eop),
        .o_data_re(bnd_re), .o_data_im(bnd_im), .o_data_vld(bnd_vld),
        .o_rbg_first(bnd_first), .o_rbg_last(bnd_last), .o_rbg_num(bnd_num),
        .o_symb_end(bnd_end)
    );

    beam_power_calc #(.BEAM(BEAM), .IW(IW), .OW(OW)) u_calc (
        .i_clk(i_clk), .i_rst(i_rst), .i_data_re(bnd_re), .i_data_im(bnd_im),
        .i_data_vld(bnd_vld), .i_rbg_first(bnd_first), .i_rbg_last(bnd_last),
        .i_rbg_num(bnd_num), .i_symb_end(bnd_end),
        .o_sum_data(sum_data), .o_sum_addr(sum_addr), .o_sum_wen(sum_wen),
        .o_symb_done(symb_done)
    );

    power_table #(.BEAM(BEAM), .OW(OW)) u_table (
        .i_clk(i_clk), .i_wen(sum_wen), .i_waddr(sum_addr), .i_wdata(sum_data),
        .i_raddr(tbl_raddr), .o_rdata(tbl_rdata)
    );

    wb_power_regs #(.OW(OW)) u_regs (
        .i_clk(i_clk), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
        .i_symb_done(symb_done), .i_sum_wen(sum_wen), .i_sum_addr(sum_addr),
        .i_tbl_rdata(tbl_rdata), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .o_en(en), .o_rbg_size(rbg_size), .o_tbl_raddr(tbl_raddr),
        .o_irq_symb_done(o_irq_symb_done)
    );

endmodule

`default_nettype wire

// File: hdl/wb_power_regs.sv
// wishbone classic slave: control and status registers, symbol counters and table read mux
`timescale 1ns/10ps
`default_nettype none

module wb_power_regs #(
    parameter int OW = 32
) (
    input  logic                                                 i_clk,
    input  logic                                                 i_rst,
    input  logic                                                 i_wb_cyc,
    input  logic                                                 i_wb_stb,
    input  logic                                                 i_wb_we,
    input  logic [beam_power_pkg::WB_AW-1:0]                     i_wb_adr,
    input  logic [beam_power_pkg::WB_DW-1:0]                     i_wb_dat,
    input  logic                                                 i_symb_done,
    input  logic                                                 i_sum_wen,
    input  logic [beam_power_pkg::RBG_AW-1:0]                    i_sum_addr,
    input  logic [OW-1:0]                                        i_tbl_rdata,
    output logic [beam_power_pkg::WB_DW-1:0]                     o_wb_dat,
    output logic                                                 o_wb_ack,
    output logic                                                 o_en,
    output logic [1:0]                                           o_rbg_size,
    output logic [beam_power_pkg::RBG_AW+beam_power_pkg::BEAM_IW-1:0] o_tbl_raddr,
    output logic                                                 o_irq_symb_done
);
    import beam_power_pkg::*;

    wb_addr_u          adr;
    logic              req;
    logic              wr_ctrl;
    logic              done_w;
    logic [15:0]       symb_cnt;
    logic [RBG_AW-1:0] rbg_cnt;
    logic              tbl_sel_q;
    logic [WB_DW-1:0]  reg_dat_q;
    logic [WB_DW-1:0]  ctrl_word;
    logic [WB_DW-1:0]  stat_word;

    assign adr = i_wb_adr;
    // no new request while acking
    assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
    assign wr_ctrl = req & i_wb_we & ~adr.regs.sel & (adr.regs.idx == REG_CTRL);

    assign ctrl_word = {{(WB_DW-3){1'b0}}, o_rbg_size, o_en};
    assign stat_word = {{(WB_DW-24){1'b0}}, rbg_cnt, symb_cnt};

    // eop rbg write
    assign done_w          = i_symb_done & i_sum_wen;
    assign o_irq_symb_done = done_w;

    // table sees the address while the request is up
    assign o_tbl_raddr = {adr.tbl.rbg, adr.tbl.beam};

    // --------------------
    // handshake and registers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack   <= 1'b0;
            tbl_sel_q  <= 1'b0;
            o_en       <= 1'b0;
            o_rbg_size <= 2'd2;
            symb_cnt   <= '0;
            rbg_cnt    <= '0;
        end else begin
            o_wb_ack <= req;
            if (req) begin
                tbl_sel_q <= adr.tbl.sel;
            end
            if (wr_ctrl) begin
                o_en       <= i_wb_dat[0];
                o_rbg_size <= i_wb_dat[2:1];
            end
            if (done_w) begin
                symb_cnt <= symb_cnt + 16'd1;
                rbg_cnt  <= i_sum_addr + RBG_AW'(1);
            end
        end
    end

    // register read data captured with the request
    always_ff @(posedge i_clk) begin
        if (req) begin
            case (adr.regs.idx)
                REG_CTRL: reg_dat_q <= ctrl_word;
                REG_STAT: reg_dat_q <= stat_word;
                default:  reg_dat_q <= '0;
            endcase
        end
    end

    // --------------------
    // read mux, table word zero extended
    assign o_wb_dat = tbl_sel_q ? WB_DW'(i_tbl_rdata) : reg_dat_q;

endmodule

`default_nettype wire

// File: hdl/power_table.sv
// power table: rbg sum storage with one all-beam write port and one registered word read port
`timescale 1ns/10ps
`default_nettype none

module power_table #(
    parameter int BEAM = 4,
    parameter int OW   = 32
) (
    input  logic                                                 i_clk,
    input  logic                                                 i_wen,
    input  logic [beam_power_pkg::RBG_AW-1:0]                    i_waddr,
    input  logic [BEAM-1:0][OW-1:0]                              i_wdata,
    input  logic [beam_power_pkg::RBG_AW+beam_power_pkg::BEAM_IW-1:0] i_raddr,
    output logic [OW-1:0]                                        o_rdata
);
    import beam_power_pkg::*;

    localparam int DEPTH = 2 ** RBG_AW;

    // one row per rbg, all beams side by side
    logic [BEAM-1:0][OW-1:0] mem [DEPTH];

    logic [RBG_AW-1:0]  rd_rbg;
    logic [BEAM_IW-1:0] rd_beam;
    logic               rd_hit;

    // read address is {rbg, beam}
    assign rd_rbg  = i_raddr[BEAM_IW +: RBG_AW];
    assign rd_beam = i_raddr[BEAM_IW-1:0];
    // beam field can address more beams than are built
    assign rd_hit  = int'(rd_beam) < BEAM;

    // --------------------
    // write port
    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // --------------------
    // read port, data one cycle after address
    always_ff @(posedge i_clk) begin
        if (rd_hit) begin
            o_rdata <= mem[rd_rbg][rd_beam];
        end else begin
            o_rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/beam_power_calc.sv
// beam power calculator: per-beam shift, abs, |i|+|q|, rbg accumulation and table write strobe
`timescale 1ns/10ps
`default_nettype none

module beam_power_calc #(
    parameter int BEAM = 4,
    parameter int IW   = 16,
    parameter int OW   = 32
) (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic [BEAM-1:0][IW-1:0]           i_data_re,
    input  logic [BEAM-1:0][IW-1:0]           i_data_im,
    input  logic                              i_data_vld,
    input  logic                              i_rbg_first,
    input  logic                              i_rbg_last,
    input  logic [beam_power_pkg::RBG_AW-1:0] i_rbg_num,
    input  logic                              i_symb_end,
    output logic [BEAM-1:0][OW-1:0]           o_sum_data,
    output logic [beam_power_pkg::RBG_AW-1:0] o_sum_addr,
    output logic                              o_sum_wen,
    output logic                              o_symb_done
);
    import beam_power_pkg::*;

    // index 0 lines up with abs, 1 with iq sum, 2 with accumulator
    logic [2:0]             vld_dly;
    logic [1:0]             first_dly;
    logic [2:0]             last_dly;
    logic [2:0]             end_dly;
    logic [2:0][RBG_AW-1:0] num_dly;
    logic                   store;

    assign store = vld_dly[2] & last_dly[2];

    // --------------------
    // flag pipeline
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_dly     <= '0;
            first_dly   <= '0;
            last_dly    <= '0;
            end_dly     <= '0;
            o_sum_wen   <= 1'b0;
            o_symb_done <= 1'b0;
        end else begin
            vld_dly     <= {vld_dly[1:0], i_data_vld};
            first_dly   <= {first_dly[0], i_rbg_first};
            last_dly    <= {last_dly[1:0], i_rbg_last};
            end_dly     <= {end_dly[1:0], i_symb_end};
            o_sum_wen   <= store;
            o_symb_done <= store & end_dly[2];
        end
    end

    always_ff @(posedge i_clk) begin
        num_dly <= {num_dly[1:0], i_rbg_num};
        if (store) begin
            o_sum_addr <= num_dly[2];
        end
    end

    // --------------------
    // per-beam datapath
    for (genvar gb = 0; gb < BEAM; gb++) begin : g_beam
        logic signed [OW-1:0] sft_re;
        logic signed [OW-1:0] sft_im;
        logic [OW-1:0]        abs_re;
        logic [OW-1:0]        abs_im;
        logic [OW-1:0]        iq_sum;
        logic [OW-1:0]        acc;
        logic [OW-1:0]        sum_q;

        // sign extend first, then arithmetic shift
        assign sft_re = OW'(signed'(i_data_re[gb])) >>> PWR_SHIFT;
        assign sft_im = OW'(signed'(i_data_im[gb])) >>> PWR_SHIFT;

        always_ff @(posedge i_clk) begin
            abs_re <= sft_re[OW-1] ? -sft_re : sft_re;
            abs_im <= sft_im[OW-1] ? -sft_im : sft_im;
            iq_sum <= abs_re + abs_im;
            // load on first re, add otherwise
            if (vld_dly[1]) begin
                acc <= first_dly[1] ? iq_sum : acc + iq_sum;
            end
            if (store) begin
                sum_q <= acc;
            end
        end

        assign o_sum_data[gb] = sum_q;
    end

endmodule

`default_nettype wire

// File: hdl/rbg_boundary_gen.sv
// rbg boundary generator: re counting, rbg first/last flags, rbg index and stream register
`timescale 1ns/10ps
`default_nettype none

module rbg_boundary_gen #(
    parameter int BEAM = 4,
    parameter int IW   = 16
) (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic                              i_en,
    input  logic [1:0]                        i_rbg_size,
    input  logic [BEAM-1:0][IW-1:0]           i_data_re,
    input  logic [BEAM-1:0][IW-1:0]           i_data_im,
    input  logic                              i_data_vld,
    input  logic                              i_data_sop,
    input  logic                              i_data_eop,
    output logic [BEAM-1:0][IW-1:0]           o_data_re,
    output logic [BEAM-1:0][IW-1:0]           o_data_im,
    output logic                              o_data_vld,
    output logic                              o_rbg_first,
    output logic                              o_rbg_last,
    output logic [beam_power_pkg::RBG_AW-1:0] o_rbg_num,
    output logic                              o_symb_end
);
    import beam_power_pkg::*;

    logic              vld;
    logic [1:0]        size_eff;
    logic [7:0]        rbg_len;
    logic [7:0]        re_cnt;
    logic [7:0]        re_cnt_nxt;
    logic              new_grp;
    logic              grp_start;
    logic              grp_end;
    logic [RBG_AW-1:0] cur_idx;
    logic [RBG_AW-1:0] cur_idx_nxt;

    // stream is dropped while disabled
    assign vld = i_data_vld & i_en;

    // code 3 behaves as 16 rb
    assign size_eff = (i_rbg_size == 2'd3) ? 2'd2 : i_rbg_size;
    // 12 re x 4, 8 or 16 rb
    assign rbg_len  = 8'd48 << size_eff;

    assign grp_start   = i_data_sop | new_grp;
    assign re_cnt_nxt  = grp_start ? 8'd1 : re_cnt + 8'd1;
    assign grp_end     = (re_cnt_nxt == rbg_len) | i_data_eop;
    assign cur_idx_nxt = i_data_sop ? '0 : (new_grp ? cur_idx + RBG_AW'(1) : cur_idx);

    // --------------------
    // group state and flags
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            re_cnt      <= '0;
            new_grp     <= 1'b1;
            // all ones, so a stream without sop still starts at index 0
            cur_idx     <= '1;
            o_data_vld  <= 1'b0;
            o_rbg_first <= 1'b0;
            o_rbg_last  <= 1'b0;
            o_symb_end  <= 1'b0;
        end else begin
            o_data_vld  <= vld;
            o_rbg_first <= vld & grp_start;
            o_rbg_last  <= vld & grp_end;
            o_symb_end  <= vld & i_data_eop;
            if (vld) begin
                re_cnt  <= re_cnt_nxt;
                new_grp <= grp_end;
                cur_idx <= cur_idx_nxt;
            end
        end
    end

    // payload stage
    always_ff @(posedge i_clk) begin
        o_data_re <= i_data_re;
        o_data_im <= i_data_im;
        o_rbg_num <= cur_idx_nxt;
    end

endmodule

`default_nettype wire

// File: hdl/beam_power_pkg.sv
// package: bus widths, table address layout, power shift and wishbone address union
`default_nettype none

package beam_power_pkg;

    // --------------------
    // bus and table widths
    localparam int WB_AW   = 12;
    localparam int WB_DW   = 32;
    localparam int RBG_AW  = 8;
    localparam int BEAM_IW = 3;

    // scaling before abs
    localparam int PWR_SHIFT = 4;

    // register indices in the register view
    localparam logic [3:0] REG_CTRL = 4'd0;
    localparam logic [3:0] REG_STAT = 4'd1;

    // --------------------
    // one wishbone address, two decodes selected by bit 11
    typedef union packed {
        struct packed {
            logic                     sel;
            logic [WB_AW-6:0]         rsvd;
            logic [3:0]               idx;
        } regs;
        struct packed {
            logic                     sel;
            logic [RBG_AW-1:0]        rbg;
            logic [BEAM_IW-1:0]       beam;
        } tbl;
    } wb_addr_u;

endpackage

`default_nettype wire
